//--- cpu.f
logic/rv_pkg.sv
logic/hazard_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/data_memory.sv
logic/hazard_unit.sv
logic/cpu.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

//--- logic/cpu.sv
`timescale 1ns/1ps

module cpu import rv_pkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    output logic                          retire_valid,
    output logic [4:0]                    retire_rd,
    output logic [31:0]                   retire_data
);
    hazard_if steer ();

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    logic [31:0] fetch_pc;
    instr_t      fetch_instruction;

    logic [4:0]  decode_rd;
    logic [4:0]  decode_rs1;
    logic [4:0]  decode_rs2;
    logic [31:0] decode_data1;
    logic [31:0] decode_data2;
    logic [31:0] decode_immediate;
    control_t    decode_control;

    logic [31:0] execute_alu_data;
    logic [31:0] execute_store_data;
    logic        branch_taken;
    logic [31:0] branch_target;

    logic [31:0] memory_read_data;

    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // flush beats hold, a cleared word decodes as a bubble
    always_ff @(posedge clk) begin
        if (!reset_n || steer.if_id_flush) begin
            if_id <= '0;
        end else if (steer.if_id_write) begin
            if_id.pc          <= fetch_pc;
            if_id.instruction <= fetch_instruction;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || steer.id_ex_flush) begin
            id_ex <= '0;
        end else begin
            id_ex.rs1       <= decode_rs1;
            id_ex.rs2       <= decode_rs2;
            id_ex.rd        <= decode_rd;
            id_ex.pc        <= if_id.pc;
            id_ex.data1     <= decode_data1;
            id_ex.data2     <= decode_data2;
            id_ex.immediate <= decode_immediate;
            id_ex.control   <= decode_control;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            ex_mem.rd          <= id_ex.rd;
            ex_mem.alu_data    <= execute_alu_data;
            ex_mem.store_data  <= execute_store_data;
            ex_mem.control     <= id_ex.control;
            mem_wb.rd          <= ex_mem.rd;
            mem_wb.alu_data    <= ex_mem.alu_data;
            mem_wb.memory_data <= memory_read_data;
            mem_wb.control     <= ex_mem.control;
        end
    end

    fetch_stage #(
        .IMEM_WORDS(IMEM_WORDS)
    ) i_fetch_stage (
        .clk(clk),
        .reset_n(reset_n),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .steer(steer.pipe),
        .pc(fetch_pc),
        .instruction(fetch_instruction)
    );

    decode_stage i_decode_stage (
        .clk(clk),
        .reset_n(reset_n),
        .instruction(if_id.instruction),
        .wb_en(wb_en),
        .wb_rd(wb_rd),
        .wb_data(wb_data),
        .rd(decode_rd),
        .rs1(decode_rs1),
        .rs2(decode_rs2),
        .data1(decode_data1),
        .data2(decode_data2),
        .immediate(decode_immediate),
        .control(decode_control)
    );

    execute_stage i_execute_stage (
        .id_ex(id_ex),
        .mem_alu_data(ex_mem.alu_data),
        .wb_data(wb_data),
        .branch_pc(id_ex.pc),
        .steer(steer.pipe),
        .alu_data(execute_alu_data),
        .store_data(execute_store_data),
        .branch_taken(branch_taken),
        .branch_target(branch_target)
    );

    data_memory #(
        .DMEM_WORDS(DMEM_WORDS)
    ) i_data_memory (
        .clk(clk),
        .address(ex_mem.alu_data),
        .write_data(ex_mem.store_data),
        .mem_write(ex_mem.control.mem_write),
        .mem_read(ex_mem.control.mem_read),
        .read_data(memory_read_data)
    );

    hazard_unit i_hazard_unit (
        .clk(clk),
        .id_ex_rs1(id_ex.rs1),
        .id_ex_rs2(id_ex.rs2),
        .id_ex_rd(id_ex.rd),
        .id_ex_control(id_ex.control),
        .ex_mem_rd(ex_mem.rd),
        .ex_mem_reg_write(ex_mem.control.reg_write),
        .mem_wb_rd(mem_wb.rd),
        .mem_wb_reg_write(mem_wb.control.reg_write),
        .if_id_rs1(decode_rs1),
        .if_id_rs2(decode_rs2),
        .branch_taken(branch_taken),
        .steer(steer.hazard)
    );

    // writeback
    assign wb_en   = mem_wb.control.reg_write;
    assign wb_rd   = mem_wb.rd;
    assign wb_data = mem_wb.control.mem_read ? mem_wb.memory_data : mem_wb.alu_data;

    // x0 writes are architecturally invisible
    assign retire_valid = wb_en && wb_rd != 5'd0;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

//--- logic/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic [31:0] write_data,
    input  logic        mem_write,
    input  logic        mem_read,
    output logic [31:0] read_data
);
    localparam int index_bits = $clog2(DMEM_WORDS);

    logic [31:0]           dmem [DMEM_WORDS];
    logic [index_bits-1:0] index;

    // word accesses only, byte offset dropped
    assign index = address[index_bits+1:2];

    always_ff @(posedge clk) begin
        if (mem_write) begin
            dmem[index] <= write_data;
        end
    end

    assign read_data = mem_read ? dmem[index] : '0;

    // one instruction per stage, so never a load and a store together
    no_read_write_overlap: assert property (
        @(posedge clk) !(mem_read && mem_write)
    ) else $error("data memory: read and write at address %h", address);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  instr_t      instruction,
    input  logic        wb_en,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    output logic [4:0]  rd,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [31:0] data1,
    output logic [31:0] data2,
    output logic [31:0] immediate,
    output control_t    control
);
    logic [31:0] regs [32];
    logic [31:0] word;
    logic [6:0]  opcode;

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        // same-cycle writeback goes straight through
        if (wb_en && wb_rd == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    assign word   = instruction;
    assign opcode = instruction.r.opcode;
    assign rd     = instruction.r.rd;
    assign rs1    = instruction.r.rs1;
    assign rs2    = instruction.r.rs2;

    always_comb begin
        control = '0;
        case (opcode)
            op_r_type: begin
                control.reg_write = 1'b1;
                case (instruction.r.funct3)
                    3'b000:  control.alu_op = instruction.r.funct7[5] ? alu_sub : alu_add;
                    3'b010:  control.alu_op = alu_slt;
                    3'b100:  control.alu_op = alu_xor;
                    3'b110:  control.alu_op = alu_or;
                    3'b111:  control.alu_op = alu_and;
                    default: control.alu_op = alu_add;
                endcase
            end
            op_imm: begin
                control.reg_write   = 1'b1;
                control.alu_src_imm = 1'b1;
                control.alu_op      = alu_add;
            end
            op_lui: begin
                control.reg_write   = 1'b1;
                control.alu_src_imm = 1'b1;
                control.alu_op      = alu_pass_b;
            end
            op_load: begin
                control.reg_write   = 1'b1;
                control.mem_read    = 1'b1;
                control.alu_src_imm = 1'b1;
                control.alu_op      = alu_add;
            end
            op_store: begin
                control.mem_write   = 1'b1;
                control.alu_src_imm = 1'b1;
                control.alu_op      = alu_add;
            end
            op_branch: begin
                control.is_branch = 1'b1;
                // funct3 000 is beq and 001 is bne
                control.branch_ne = instruction.r.funct3[0];
                control.alu_op    = alu_sub;
            end
            default: control = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_store:  immediate = {{20{word[31]}}, word[31:25], word[11:7]};
            op_branch: immediate = {{19{word[31]}}, word[31], word[7], word[30:25],
                                    word[11:8], 1'b0};
            op_lui:    immediate = {word[31:12], 12'b0};
            default:   immediate = {{20{instruction.i.imm[11]}}, instruction.i.imm};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            regs <= '{default: '0};
        end else if (wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        data1 = read_port(rs1);
        data2 = read_port(rs2);
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  id_ex_t      id_ex,
    input  logic [31:0] mem_alu_data,
    input  logic [31:0] wb_data,
    input  logic [31:0] branch_pc,
    hazard_if.pipe      steer,
    output logic [31:0] alu_data,
    output logic [31:0] store_data,
    output logic        branch_taken,
    output logic [31:0] branch_target
);
    logic [31:0] operand_a;
    logic [31:0] rs2_value;
    logic [31:0] operand_b;
    logic        operands_equal;

    function automatic logic [31:0] forward(input fwd_sel_t sel, input logic [31:0] reg_data);
        case (sel)
            fwd_from_mem: return mem_alu_data;
            fwd_from_wb:  return wb_data;
            default:      return reg_data;
        endcase
    endfunction

    always_comb begin
        operand_a = forward(steer.forward_a, id_ex.data1);
        rs2_value = forward(steer.forward_b, id_ex.data2);
        operand_b = id_ex.control.alu_src_imm ? id_ex.immediate : rs2_value;
    end

    always_comb begin
        case (id_ex.control.alu_op)
            alu_add:    alu_data = operand_a + operand_b;
            alu_sub:    alu_data = operand_a - operand_b;
            alu_and:    alu_data = operand_a & operand_b;
            alu_or:     alu_data = operand_a | operand_b;
            alu_xor:    alu_data = operand_a ^ operand_b;
            alu_slt:    alu_data = ($signed(operand_a) < $signed(operand_b)) ? 32'd1 : 32'd0;
            alu_pass_b: alu_data = operand_b;
            default:    alu_data = '0;
        endcase
    end

    // sw stores the forwarded rs2, not the immediate
    assign store_data = rs2_value;

    // not-taken prediction, so only a taken branch redirects
    assign operands_equal = operand_a == rs2_value;
    assign branch_taken   = id_ex.control.is_branch &&
                            (id_ex.control.branch_ne ? !operands_equal : operands_equal);
    assign branch_target  = branch_pc + id_ex.immediate;

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    input  logic                          branch_taken,
    input  logic [31:0]                   branch_target,
    hazard_if.pipe                        steer,
    output logic [31:0]                   pc,
    output instr_t                        instruction
);
    localparam int index_bits = $clog2(IMEM_WORDS);

    logic [31:0] imem [IMEM_WORDS];

    // program load port, used while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // redirect wins over a load-use hold
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (steer.pc_write) begin
            pc <= pc + 32'd4;
        end
    end

    assign instruction = imem[pc[index_bits+1:2]];

    // branch targets come from execute, so this covers the whole redirect path
    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!reset_n) pc[1:0] == 2'b00
    ) else $error("fetch: pc %h is not word aligned", pc);

endmodule

//--- logic/hazard_if.sv
`timescale 1ns/1ps

interface hazard_if import rv_pkg::*; ();
    // levels, all take effect at the next rising edge
    logic     pc_write;
    logic     if_id_write;
    logic     if_id_flush;
    logic     id_ex_flush;
    fwd_sel_t forward_a;
    fwd_sel_t forward_b;

    modport hazard (
        output pc_write,
        output if_id_write,
        output if_id_flush,
        output id_ex_flush,
        output forward_a,
        output forward_b
    );

    modport pipe (
        input pc_write,
        input if_id_write,
        input if_id_flush,
        input id_ex_flush,
        input forward_a,
        input forward_b
    );
endinterface

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    input  logic       clk,
    input  logic [4:0] id_ex_rs1,
    input  logic [4:0] id_ex_rs2,
    input  logic [4:0] id_ex_rd,
    input  control_t   id_ex_control,
    input  logic [4:0] ex_mem_rd,
    input  logic       ex_mem_reg_write,
    input  logic [4:0] mem_wb_rd,
    input  logic       mem_wb_reg_write,
    input  logic [4:0] if_id_rs1,
    input  logic [4:0] if_id_rs2,
    input  logic       branch_taken,
    hazard_if.hazard   steer
);
    logic load_use;

    // newest producer first and x0 never forwarded
    function automatic fwd_sel_t select_source(input logic [4:0] rs);
        if (ex_mem_reg_write && ex_mem_rd != 5'd0 && ex_mem_rd == rs) begin
            return fwd_from_mem;
        end
        if (mem_wb_reg_write && mem_wb_rd != 5'd0 && mem_wb_rd == rs) begin
            return fwd_from_wb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        steer.forward_a = select_source(id_ex_rs1);
        steer.forward_b = select_source(id_ex_rs2);
    end

    assign load_use = id_ex_control.mem_read && id_ex_rd != 5'd0 &&
                      (id_ex_rd == if_id_rs1 || id_ex_rd == if_id_rs2);

    // a taken branch squashes the stalled instruction anyway
    assign steer.pc_write    = !load_use || branch_taken;
    assign steer.if_id_write = !load_use || branch_taken;
    assign steer.if_id_flush = branch_taken;
    assign steer.id_ex_flush = branch_taken || load_use;

    // holding IF/ID without a bubble would issue the instruction twice
    hold_needs_bubble: assert property (
        @(posedge clk) !steer.if_id_write |=> id_ex_control == '0
    ) else $error("hazard: IF/ID held without an ID/EX bubble");

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

    // RV32I major opcodes handled by the core
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // one instruction word, register view and immediate view
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    is_branch;
        logic    branch_ne;
        alu_op_t alu_op;
    } control_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_t;

    typedef struct packed {
        logic [31:0] pc;
        instr_t      instruction;
    } if_id_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] data1;
        logic [31:0] data2;
        logic [31:0] immediate;
        control_t    control;
    } id_ex_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] alu_data;
        logic [31:0] store_data;
        control_t    control;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] alu_data;
        logic [31:0] memory_data;
        control_t    control;
    } mem_wb_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpu_tb -f cpu.f

# the simulator status alone does not decide the result
output=$(./obj_dir/Vcpu_tb 2>&1) || true
echo "$output"
echo "$output" | grep -qx "Test OK"

//--- testbench/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        prog_we,
    input  logic [7:0]  prog_addr,
    input  logic [31:0] prog_data,
    input  logic        retire_valid,
    input  logic [4:0]  retire_rd,
    input  logic [31:0] retire_data,
    input  logic        run_done,
    output logic        report_done,
    output logic        all_retired,
    output int          errors
);
    // beq x0, x0, 0
    localparam logic [31:0] self_loop = 32'h0000_0063;

    logic [31:0] imem_model [256];
    logic [31:0] dmem_model [256];
    logic [31:0] regs [32];
    // expected register writes in program order, tag bit n marks behavior n+1
    logic [4:0]  exp_rd [64];
    logic [31:0] exp_data [64];
    logic [3:0]  exp_tags [64];
    int          exp_count = 0;
    int          seen = 0;
    int          error_total = 0;
    int          checks [5] = '{default: 0};
    int          failures [5] = '{default: 0};
    logic        model_built = 1'b0;
    logic        reported = 1'b0;

    assign all_retired = model_built && seen == exp_count;
    assign report_done = reported;
    assign errors      = error_total;

    initial $timeformat(-9, 0, " ns", 0);

    function automatic string behavior_name(input int b);
        case (b)
            0: return "dependent alu results";
            1: return "store and load";
            2: return "branch outcomes";
            3: return "x0 writes and reads";
            default: return "reset quiet and retirement count";
        endcase
    endfunction

    task automatic note_failure(input logic [4:0] tags);
        error_total++;
        for (int b = 0; b < 5; b++) begin
            if (tags[b]) begin
                failures[b]++;
            end
        end
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] result;
        logic [3:0]  tags;
        logic        writes;
        logic        after_branch;
        int          steps;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int m = 0; m < 256; m++) begin
            dmem_model[m] = '0;
        end
        pc = '0;
        steps = 0;
        after_branch = 1'b0;
        while (imem_model[pc[9:2]] != self_loop && steps < 1000) begin
            word    = imem_model[pc[9:2]];
            a       = regs[word[19:15]];
            b       = regs[word[24:20]];
            imm_i   = {{20{word[31]}}, word[31:20]};
            pc_next = pc + 32'd4;
            result  = '0;
            writes  = 1'b1;
            tags    = after_branch ? 4'b0100 : 4'b0000;
            case (word[6:0])
                7'b0110011: begin
                    tags |= 4'b0001;
                    if (word[19:15] == 5'd0 || word[24:20] == 5'd0) begin
                        tags |= 4'b1000;
                    end
                    case (word[14:12])
                        3'b000:  result = word[30] ? a - b : a + b;
                        3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  result = a ^ b;
                        3'b110:  result = a | b;
                        3'b111:  result = a & b;
                        default: result = a + b;
                    endcase
                end
                7'b0010011: begin
                    tags |= (word[19:15] == 5'd0) ? 4'b1001 : 4'b0001;
                    result = a + imm_i;
                end
                7'b0110111: begin
                    tags |= 4'b0001;
                    result = {word[31:12], 12'b0};
                end
                7'b0000011: begin
                    tags |= 4'b0010;
                    addr = a + imm_i;
                    result = dmem_model[addr[9:2]];
                end
                7'b0100011: begin
                    writes = 1'b0;
                    addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
                    dmem_model[addr[9:2]] = b;
                end
                7'b1100011: begin
                    writes = 1'b0;
                    after_branch = 1'b1;
                    // funct3 bit 0 selects bne
                    if ((a == b) != word[12]) begin
                        pc_next = pc + {{19{word[31]}}, word[31], word[7], word[30:25],
                                        word[11:8], 1'b0};
                    end
                end
                default: writes = 1'b0;
            endcase
            if (writes && word[11:7] != 5'd0 && exp_count < 64) begin
                regs[word[11:7]]    = result;
                exp_rd[exp_count]   = word[11:7];
                exp_data[exp_count] = result;
                exp_tags[exp_count] = tags;
                exp_count++;
                after_branch = 1'b0;
            end
            pc = pc_next;
            steps++;
        end
        if (steps >= 1000) begin
            $display("error: the model never reached the self-loop of the loaded program");
            error_total++;
        end
    endtask

    task automatic compare_retirement();
        if (seen >= exp_count) begin
            $display("error: x%0d retired at %t after the last expected register write",
                     retire_rd, $time);
            note_failure(5'b10100);
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (exp_tags[seen][b]) begin
                    checks[b]++;
                end
            end
            if (retire_rd != exp_rd[seen] || retire_data != exp_data[seen]) begin
                $display("FAIL %t: retirement %0d wrote x%0d = %h, expected x%0d = %h", $time,
                         seen, retire_rd, retire_data, exp_rd[seen], exp_data[seen]);
                note_failure({1'b0, exp_tags[seen]});
            end
        end
        if (retire_rd == 5'd0) begin
            $display("FAIL %t: a write to x0 showed up as a retirement", $time);
            note_failure(5'b01000);
        end
        seen++;
    endtask

    task automatic print_report();
        int passed;
        passed = 0;
        checks[4]++;
        if (seen != exp_count) begin
            $display("FAIL %t: %0d retirements, the model expects %0d", $time, seen, exp_count);
            note_failure(5'b10000);
        end
        for (int b = 0; b < 5; b++) begin
            if (checks[b] == 0) begin
                $display("error: test %0d was never exercised by the program", b + 1);
                error_total++;
            end
            $display("test %0d %s: %0d checks, %0d errors, %s", b + 1, behavior_name(b),
                     checks[b], failures[b],
                     (failures[b] == 0 && checks[b] > 0) ? "pass" : "fail");
            if (failures[b] == 0 && checks[b] > 0) begin
                passed++;
            end
        end
        $display("summary: %0d of 5 tests passed, %0d retirements, %0d errors",
                 passed, seen, error_total);
    endtask

    always @(negedge clk) begin
        if (!reset_n) begin
            if (prog_we) begin
                imem_model[prog_addr] = prog_data;
            end
            checks[4]++;
            if (retire_valid) begin
                $display("error: retire_valid went high at %t while the core was in reset", $time);
                note_failure(5'b10000);
            end
        end else begin
            if (!model_built) begin
                run_model();
                model_built = 1'b1;
            end
            if (retire_valid) begin
                compare_retirement();
            end
        end
        if (run_done && !reported) begin
            print_report();
            reported = 1'b1;
        end
    end

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    localparam int prog_words = 68;
    localparam int loop_index = 63;
    localparam int data_slots = 8;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        prog_we;
    logic [7:0]  prog_addr;
    logic [31:0] prog_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        run_done;
    logic        report_done;
    logic        all_retired;
    logic        timed_out;
    int          errors;
    int          seed;
    logic [31:0] program_words [prog_words];

    always #50 clk = ~clk;

    cpu i_cpu (
        .clk(clk),
        .reset_n(reset_n),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    cpu_checker i_cpu_checker (
        .clk(clk),
        .reset_n(reset_n),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .run_done(run_done),
        .report_done(report_done),
        .all_retired(all_retired),
        .errors(errors)
    );

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // x0..x7 only, keeps dependencies dense
    function automatic logic [4:0] pick_reg();
        return 5'(pick(8));
    endfunction

    function automatic logic [31:0] r_type_word(input logic [2:0] funct3, input logic alt,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] funct3, input logic [4:0] rd,
                                             input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] offset, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic ne);
        return {offset[12], offset[10:5], rs2, rs1, 2'b00, ne, offset[4:1], offset[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic build_program();
        int          span;
        logic [2:0]  funct3;
        logic        alt;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] offset;
        // every data word gets defined before any load
        for (int i = 0; i < data_slots; i++) begin
            program_words[i] = store_word(12'(4 * i), 5'd0, 5'd0);
        end
        for (int i = data_slots; i < loop_index; i++) begin
            rs1 = pick_reg();
            rs2 = pick_reg();
            offset = 12'(4 * pick(data_slots));
            case (pick(10))
                0, 1, 2: begin
                    case (pick(6))
                        0: {funct3, alt} = {3'b000, 1'b0};
                        1: {funct3, alt} = {3'b000, 1'b1};
                        2: {funct3, alt} = {3'b111, 1'b0};
                        3: {funct3, alt} = {3'b110, 1'b0};
                        4: {funct3, alt} = {3'b100, 1'b0};
                        default: {funct3, alt} = {3'b010, 1'b0};
                    endcase
                    program_words[i] = r_type_word(funct3, alt, pick_reg(), rs1, rs2);
                end
                3, 4: program_words[i] = imm_word(12'(pick(4096)), rs1, 3'b000, pick_reg(),
                                                  7'b0010011);
                5: program_words[i] = lui_word(20'(pick(1 << 20)), pick_reg());
                6: program_words[i] = imm_word(offset, 5'd0, 3'b010, pick_reg(), 7'b0000011);
                7: program_words[i] = store_word(offset, rs2, 5'd0);
                default: begin
                    // forward only, never past the self-loop
                    span = 1 + pick(6);
                    if (i + span > loop_index) begin
                        span = loop_index - i;
                    end
                    if (pick(3) == 0) begin
                        rs2 = rs1;
                    end
                    program_words[i] = branch_word(13'(4 * span), rs2, rs1, pick(2) == 1);
                end
            endcase
        end
        program_words[loop_index] = branch_word(13'd0, 5'd0, 5'd0, 1'b0);
        // fetch runs a little past the loop, x0 writes there are harmless
        for (int i = loop_index + 1; i < prog_words; i++) begin
            program_words[i] = imm_word(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011);
        end
    endtask

    initial begin
        int cycles;
        seed = 52;
        reset_n = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run_done = 1'b0;
        timed_out = 1'b0;
        build_program();
        repeat (3) @(posedge clk);
        // reset stays low while the program goes in
        for (int i = 0; i < prog_words; i++) begin
            #1;
            prog_we = 1'b1;
            prog_addr = 8'(i);
            prog_data = program_words[i];
            @(posedge clk);
        end
        #1;
        prog_we = 1'b0;
        reset_n = 1'b1;
        cycles = 0;
        while (!all_retired && cycles < 1000) begin
            @(posedge clk);
            cycles++;
        end
        if (!all_retired) begin
            timed_out = 1'b1;
            $display("error: retirements stopped, %0d cycles after reset the program is unfinished",
                     cycles);
        end else begin
            // core spins in the self-loop, nothing more may retire
            for (int c = 0; c < 20; c++) begin
                @(posedge clk);
            end
        end
        #1;
        run_done = 1'b1;
        cycles = 0;
        while (!report_done && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (timed_out || !report_done || errors != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    end

endmodule
